// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int STRB_W         = 4;
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 7;
    localparam int WORD_IDX_W     = 3;
    localparam int WORDS_PER_LINE = 8;
    localparam int NUM_SETS       = 128;

    // address is tag 31..12, index 11..5, word 4..2, byte 1..0
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_ADDR,
        ST_WB_DATA,
        ST_WB_RESP,
        ST_REFILL_ADDR,
        ST_REFILL_DATA
    } cache_state_t;

endpackage

// ==== verilog/dcache_way.sv ====
`timescale 1ns/1ps

module dcache_way
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  index_t    index,
    input  tag_t      tag,
    input  word_idx_t word,
    input  logic      store_en,
    input  word_t     store_data,
    input  strb_t     store_strb,
    input  logic      fill_en,
    input  word_t     fill_data,
    input  logic      fill_done,
    input  logic      clean,
    output logic      hit,
    output word_t     word_rdata,
    output logic      line_dirty,
    output tag_t      line_tag
);

    logic [NUM_SETS-1:0] valid;
    logic [NUM_SETS-1:0] dirty;
    tag_t                tag_mem [NUM_SETS];
    word_t               data_mem [NUM_SETS*WORDS_PER_LINE];

    // word slot inside the flat data array
    logic [INDEX_W+WORD_IDX_W-1:0] slot;

    assign slot = {index, word};

    // combinational read port
    assign line_tag   = tag_mem[index];
    assign hit        = valid[index] && (tag_mem[index] == tag);
    assign line_dirty = valid[index] && dirty[index];
    assign word_rdata = data_mem[slot];

    // byte merge on store, full word on refill
    always_ff @(posedge clk)
    begin
        if (store_en)
        begin
            for (int b = 0; b < STRB_W; b++)
            begin
                if (store_strb[b])
                begin
                    data_mem[slot][8*b +: 8] <= store_data[8*b +: 8];
                end
            end
        end
        else if (fill_en)
        begin
            data_mem[slot] <= fill_data;
        end
    end

    // tag written with the last refill beat
    always_ff @(posedge clk)
    begin
        if (fill_en && fill_done)
        begin
            tag_mem[index] <= tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (fill_en && fill_done)
        begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end
        else if (store_en)
        begin
            dirty[index] <= 1'b1;
        end
        else if (clean)
        begin
            dirty[index] <= 1'b0;
        end
    end

    // controller never stores into a way that is being refilled
    a_store_fill_excl: assert property (@(posedge clk) disable iff (rst)
        !(store_en && fill_en));

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  logic      wr,
    input  addr_t     addr,
    input  word_t     wdata,
    input  strb_t     wstrb,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     rdata,
    output addr_t     araddr,
    output logic      arvalid,
    input  logic      arready,
    input  word_t     rdata_m,
    input  logic      rvalid,
    input  logic      rlast,
    output logic      rready,
    output addr_t     awaddr,
    output logic      awvalid,
    input  logic      awready,
    output word_t     wdata_m,
    output logic      wvalid,
    output logic      wlast,
    input  logic      wready,
    input  logic      bvalid,
    output logic      bready,
    input  logic      hit_0,
    input  logic      hit_1,
    input  word_t     word_rdata_0,
    input  word_t     word_rdata_1,
    input  logic      line_dirty_0,
    input  logic      line_dirty_1,
    input  tag_t      line_tag_0,
    input  tag_t      line_tag_1,
    output index_t    index,
    output tag_t      tag,
    output word_idx_t word,
    output logic      store_en_0,
    output logic      store_en_1,
    output word_t     store_data,
    output strb_t     store_strb,
    output logic      fill_en_0,
    output logic      fill_en_1,
    output word_t     fill_data,
    output logic      fill_done,
    output logic      clean_0,
    output logic      clean_1
);

    cache_state_t        state;
    cache_state_t        state_nx;
    addr_t               req_addr;
    logic                req_wr;
    word_t               req_wdata;
    strb_t               req_strb;
    word_idx_t           beat;
    logic [NUM_SETS-1:0] lru;

    logic hit;
    logic victim;
    logic victim_dirty;
    tag_t victim_tag;
    logic in_burst;

    // request held until data_ok
    always_ff @(posedge clk)
    begin
        if (addr_ok)
        begin
            req_addr  <= addr;
            req_wr    <= wr;
            req_wdata <= wdata;
            req_strb  <= wstrb;
        end
    end

    assign index = req_addr[WORD_IDX_W+2 +: INDEX_W];
    assign tag   = req_addr[ADDR_W-1 -: TAG_W];

    // burst states walk the line with the beat counter
    assign in_burst = (state == ST_WB_DATA) || (state == ST_REFILL_DATA);
    assign word     = in_burst ? beat : req_addr[2 +: WORD_IDX_W];

    // lru bit holds the most recent way, victim is the other
    assign hit          = hit_0 || hit_1;
    assign victim       = ~lru[index];
    assign victim_dirty = victim ? line_dirty_1 : line_dirty_0;
    assign victim_tag   = victim ? line_tag_1 : line_tag_0;

    assign addr_ok = req && (state == ST_IDLE);
    assign data_ok = (state == ST_LOOKUP) && hit;
    assign rdata   = hit_1 ? word_rdata_1 : word_rdata_0;

    assign store_en_0 = (state == ST_LOOKUP) && req_wr && hit_0;
    assign store_en_1 = (state == ST_LOOKUP) && req_wr && hit_1;
    assign store_data = req_wdata;
    assign store_strb = req_strb;

    assign fill_en_0 = (state == ST_REFILL_DATA) && rvalid && !victim;
    assign fill_en_1 = (state == ST_REFILL_DATA) && rvalid && victim;
    assign fill_data = rdata_m;
    assign fill_done = (state == ST_REFILL_DATA) && rvalid && rlast;

    assign clean_0 = (state == ST_WB_RESP) && bvalid && !victim;
    assign clean_1 = (state == ST_WB_RESP) && bvalid && victim;

    // write-back of the victim line
    assign awaddr  = {victim_tag, index, {(WORD_IDX_W+2){1'b0}}};
    assign awvalid = (state == ST_WB_ADDR);
    assign wdata_m = victim ? word_rdata_1 : word_rdata_0;
    assign wvalid  = (state == ST_WB_DATA);
    assign wlast   = (beat == 3'd7);
    assign bready  = (state == ST_WB_RESP);

    // line-aligned refill
    assign araddr  = {req_addr[ADDR_W-1:WORD_IDX_W+2], {(WORD_IDX_W+2){1'b0}}};
    assign arvalid = (state == ST_REFILL_ADDR);
    assign rready  = (state == ST_REFILL_DATA);

    always_comb
    begin
        state_nx = state;
        case (state)
            ST_IDLE:
                if (req)
                    state_nx = ST_LOOKUP;
            ST_LOOKUP:
                if (hit)
                    state_nx = ST_IDLE;
                else if (victim_dirty)
                    state_nx = ST_WB_ADDR;
                else
                    state_nx = ST_REFILL_ADDR;
            ST_WB_ADDR:
                if (awready)
                    state_nx = ST_WB_DATA;
            ST_WB_DATA:
                if (wready && wlast)
                    state_nx = ST_WB_RESP;
            ST_WB_RESP:
                if (bvalid)
                    state_nx = ST_REFILL_ADDR;
            ST_REFILL_ADDR:
                if (arready)
                    state_nx = ST_REFILL_DATA;
            ST_REFILL_DATA:
                if (rvalid && rlast)
                    state_nx = ST_LOOKUP;
            default:
                state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_nx;
        end
    end

    // beat counter, restarts on each address handshake
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat <= '0;
        end
        else if ((state == ST_WB_ADDR) || (state == ST_REFILL_ADDR))
        begin
            beat <= '0;
        end
        else if (((state == ST_WB_DATA) && wready) || ((state == ST_REFILL_DATA) && rvalid))
        begin
            beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lru <= '0;
        end
        else if ((state == ST_LOOKUP) && hit)
        begin
            lru[index] <= hit_1;
        end
    end

    // a line lives in one way only
    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        (state == ST_LOOKUP) |-> !(hit_0 && hit_1));

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)));

    // memory must close the burst after exactly 8 beats
    a_rlast_beat: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rready && rlast) |-> (beat == 3'd7));

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  req,
    input  logic  wr,
    input  addr_t addr,
    input  word_t wdata,
    input  strb_t wstrb,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata,
    output addr_t araddr,
    output logic  arvalid,
    input  logic  arready,
    input  word_t rdata_m,
    input  logic  rvalid,
    input  logic  rlast,
    output logic  rready,
    output addr_t awaddr,
    output logic  awvalid,
    input  logic  awready,
    output word_t wdata_m,
    output logic  wvalid,
    output logic  wlast,
    input  logic  wready,
    input  logic  bvalid,
    output logic  bready
);

    // shared way controls
    index_t    index;
    tag_t      tag;
    word_idx_t word;
    word_t     store_data;
    strb_t     store_strb;
    word_t     fill_data;
    logic      fill_done;

    // per way
    logic  store_en_0;
    logic  store_en_1;
    logic  fill_en_0;
    logic  fill_en_1;
    logic  clean_0;
    logic  clean_1;
    logic  hit_0;
    logic  hit_1;
    word_t word_rdata_0;
    word_t word_rdata_1;
    logic  line_dirty_0;
    logic  line_dirty_1;
    tag_t  line_tag_0;
    tag_t  line_tag_1;

    dcache_way way_0 (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .tag        (tag),
        .word       (word),
        .store_en   (store_en_0),
        .store_data (store_data),
        .store_strb (store_strb),
        .fill_en    (fill_en_0),
        .fill_data  (fill_data),
        .fill_done  (fill_done),
        .clean      (clean_0),
        .hit        (hit_0),
        .word_rdata (word_rdata_0),
        .line_dirty (line_dirty_0),
        .line_tag   (line_tag_0)
    );

    dcache_way way_1 (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .tag        (tag),
        .word       (word),
        .store_en   (store_en_1),
        .store_data (store_data),
        .store_strb (store_strb),
        .fill_en    (fill_en_1),
        .fill_data  (fill_data),
        .fill_done  (fill_done),
        .clean      (clean_1),
        .hit        (hit_1),
        .word_rdata (word_rdata_1),
        .line_dirty (line_dirty_1),
        .line_tag   (line_tag_1)
    );

    dcache_ctrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .wr           (wr),
        .addr         (addr),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata_m      (rdata_m),
        .rvalid       (rvalid),
        .rlast        (rlast),
        .rready       (rready),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata_m      (wdata_m),
        .wvalid       (wvalid),
        .wlast        (wlast),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready),
        .hit_0        (hit_0),
        .hit_1        (hit_1),
        .word_rdata_0 (word_rdata_0),
        .word_rdata_1 (word_rdata_1),
        .line_dirty_0 (line_dirty_0),
        .line_dirty_1 (line_dirty_1),
        .line_tag_0   (line_tag_0),
        .line_tag_1   (line_tag_1),
        .index        (index),
        .tag          (tag),
        .word         (word),
        .store_en_0   (store_en_0),
        .store_en_1   (store_en_1),
        .store_data   (store_data),
        .store_strb   (store_strb),
        .fill_en_0    (fill_en_0),
        .fill_en_1    (fill_en_1),
        .fill_data    (fill_data),
        .fill_done    (fill_done),
        .clean_0      (clean_0),
        .clean_1      (clean_1)
    );

endmodule

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output word_t rdata_m,
    output logic  rvalid,
    output logic  rlast,
    input  logic  rready,
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  word_t wdata_m,
    input  logic  wvalid,
    input  logic  wlast,
    output logic  wready,
    output logic  bvalid,
    input  logic  bready
);

    integer seed = 10102;

    // only written words are stored and the rest follow the fill pattern
    word_t mem [addr_t];

    logic      rd_active;
    addr_t     rd_addr;
    word_idx_t rd_beat;
    logic      wr_active;
    addr_t     wr_addr;
    word_idx_t wr_beat;
    logic      b_pend;
    logic      r_fire;
    logic      b_fire;

    function automatic word_t mem_read(input addr_t a);
        if (mem.exists(a))
            return mem[a];
        return a ^ 32'h5a5a0000;
    endfunction

    // high on about three cycles out of four
    function automatic logic stall_pick();
        return (($random(seed) & 3) != 0);
    endfunction

    initial
    begin
        arready = 1'b0;
        rdata_m = '0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
    end

    // burst bookkeeping at the handshake edge
    always @(posedge clk)
    begin
        if (rst)
        begin
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_pend    <= 1'b0;
            r_fire    <= 1'b0;
            b_fire    <= 1'b0;
            rd_addr   <= '0;
            rd_beat   <= '0;
            wr_beat   <= '0;
        end
        else
        begin
            r_fire <= rvalid && rready;
            b_fire <= bvalid && bready;
            if (arvalid && arready)
            begin
                rd_active <= 1'b1;
                rd_addr   <= araddr;
                rd_beat   <= '0;
            end
            else if (rvalid && rready)
            begin
                rd_beat <= rd_beat + 3'd1;
                if (rlast)
                    rd_active <= 1'b0;
            end
            if (awvalid && awready)
            begin
                wr_active <= 1'b1;
                wr_addr   <= awaddr;
                wr_beat   <= '0;
            end
            else if (wvalid && wready)
            begin
                mem[wr_addr + {27'd0, wr_beat, 2'b00}] = wdata_m;
                wr_beat <= wr_beat + 3'd1;
                if (wlast)
                begin
                    wr_active <= 1'b0;
                    b_pend    <= 1'b1;
                end
            end
            if (bvalid && bready)
                b_pend <= 1'b0;
        end
    end

    // outputs change on the falling edge and valid is held until taken
    always @(negedge clk)
    begin
        arready = !rd_active && stall_pick();
        if (!rvalid || r_fire)
            rvalid = rd_active && stall_pick();
        rdata_m = mem_read(rd_addr + {27'd0, rd_beat, 2'b00});
        rlast   = rd_active && (rd_beat == 3'd7);
        awready = !wr_active && !b_pend && stall_pick();
        wready  = wr_active && stall_pick();
        if (!bvalid || b_fire)
            bvalid = b_pend && stall_pick();
    end

endmodule

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int NUM_REQ        = 300;
    localparam int CYCLES_PER_REQ = 60;
    localparam int TIMEOUT_CYCLES = NUM_REQ * CYCLES_PER_REQ;
    localparam int NUM_RANDOM     = 280;

    logic  clk;
    logic  rst;
    logic  req;
    logic  wr;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  addr_ok;
    logic  data_ok;
    word_t rdata;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    word_t rdata_m;
    logic  rvalid;
    logic  rlast;
    logic  rready;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    word_t wdata_m;
    logic  wvalid;
    logic  wlast;
    logic  wready;
    logic  bvalid;
    logic  bready;

    integer    seed = 10102;
    word_t     shadow [addr_t];
    logic      cur_wr;
    word_t     exp_rdata;
    addr_t     cur_line;
    logic      expect_fast;
    logic      victim_check;
    addr_t     victim_line;
    logic      wb_seen;
    addr_t     wb_addr;
    word_idx_t wb_beat;
    word_t     exp_wdata;
    int        accept_count = 0;
    int        cycle_count = 0;

    always #20 clk = ~clk;

    dcache_top dcache_top_i (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .wr      (wr),
        .addr    (addr),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata_m (rdata_m),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata_m (wdata_m),
        .wvalid  (wvalid),
        .wlast   (wlast),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    axi_mem_model mem_model (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata_m (rdata_m),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata_m (wdata_m),
        .wvalid  (wvalid),
        .wlast   (wlast),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    // memory content as the cpu sees it
    function automatic word_t shadow_read(input addr_t a);
        addr_t w;
        w = {a[31:2], 2'b00};
        if (shadow.exists(w))
            return shadow[w];
        return w ^ 32'h5a5a0000;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t d, input strb_t s);
        word_t m;
        m = old;
        for (int b = 0; b < 4; b++)
        begin
            if (s[b])
                m[8*b +: 8] = d[8*b +: 8];
        end
        return m;
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    // one request, from issue to data_ok
    task automatic run_request(input logic is_wr, input addr_t a, input word_t d,
                               input strb_t s, input logic fast);
        int    start;
        word_t old;
        start = accept_count;
        old   = shadow_read(a);
        if (is_wr)
            shadow[{a[31:2], 2'b00}] = merge_bytes(old, d, s);
        cur_wr      = is_wr;
        exp_rdata   = old;
        cur_line    = {a[31:5], 5'd0};
        expect_fast = fast;
        req   = 1'b1;
        wr    = is_wr;
        addr  = a;
        wdata = d;
        wstrb = s;
        do
            @(negedge clk);
        while (accept_count == start);
        req = 1'b0;
        while (!data_ok)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic run_random(input int count);
        word_t r;
        word_t d;
        addr_t a;
        for (int i = 0; i < count; i++)
        begin
            r = $random(seed);
            d = $random(seed);
            // tags 0..3 over sets 0..3, so lines collide and get evicted
            a = {18'd0, r[1:0], 5'd0, r[3:2], r[6:4], 2'b00};
            run_request(r[7], a, d, r[11:8], 1'b0);
        end
    endtask

    always @(posedge clk)
    begin
        if (addr_ok)
            accept_count <= accept_count + 1;
        if (awvalid && awready)
        begin
            wb_addr <= awaddr;
            wb_beat <= '0;
        end
        else if (wvalid && wready)
            wb_beat <= wb_beat + 3'd1;
        if (!victim_check)
            wb_seen <= 1'b0;
        else if (awvalid && awready)
            wb_seen <= 1'b1;
    end

    // expected word for the write-back beat on the bus
    always @(negedge clk)
    begin
        exp_wdata = shadow_read(wb_addr + {27'd0, wb_beat, 2'b00});
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            stop_with_failure();
        end
    end

    a_reset_quiet: assert property (@(posedge clk) $fell(rst) |->
        !(addr_ok || data_ok || arvalid || awvalid || wvalid || rready || bready))
        else report_error("outputs not idle after reset");

    a_addr_ok_req: assert property (@(posedge clk) disable iff (rst) !req |-> !addr_ok)
        else report_error("addr_ok without req");

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        (data_ok && !cur_wr) |-> (rdata == exp_rdata))
        else report_error("read data differs from shadow memory");

    a_fast_hit: assert property (@(posedge clk) disable iff (rst)
        (addr_ok && expect_fast) |=> (data_ok && !arvalid))
        else report_error("hit on resident line not answered in one cycle");

    a_aw_align: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> (awaddr[4:0] == 5'd0))
        else report_error("write-back address not line aligned");

    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        (wvalid && wready) |-> (wdata_m == exp_wdata))
        else report_error("write-back beat differs from shadow line");

    a_wlast: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> (wlast == (wb_beat == 3'd7)))
        else report_error("wlast not on the 8th beat only");

    a_ar_line: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> (araddr == cur_line))
        else report_error("refill address is not the aligned request line");

    a_lru_victim: assert property (@(posedge clk) disable iff (rst)
        (awvalid && victim_check) |-> (awaddr == victim_line))
        else report_error("write-back of the wrong lru victim");

    a_lru_wb_seen: assert property (@(posedge clk) disable iff (rst)
        (data_ok && victim_check) |-> wb_seen)
        else report_error("expected victim write-back did not happen");

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        req          = 1'b0;
        wr           = 1'b0;
        addr         = '0;
        wdata        = '0;
        wstrb        = '0;
        cur_wr       = 1'b0;
        exp_rdata    = '0;
        cur_line     = '0;
        expect_fast  = 1'b0;
        victim_check = 1'b0;
        victim_line  = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // set 5: A and B dirty, A touched last, so C evicts B
        run_request(1'b1, 32'h0010_00a8, 32'h1111_2222, 4'b1111, 1'b0);
        run_request(1'b1, 32'h0010_10ac, 32'h3333_4444, 4'b1111, 1'b0);
        run_request(1'b0, 32'h0010_00a8, 32'h0, 4'b0000, 1'b1);
        victim_line  = 32'h0010_10a0;
        victim_check = 1'b1;
        run_request(1'b0, 32'h0010_20a0, 32'h0, 4'b0000, 1'b0);
        victim_check = 1'b0;
        run_request(1'b0, 32'h0010_10ac, 32'h0, 4'b0000, 1'b0);

        // refill, then hits and byte merges in the same line
        run_request(1'b0, 32'h0020_0120, 32'h0, 4'b0000, 1'b0);
        run_request(1'b0, 32'h0020_0134, 32'h0, 4'b0000, 1'b1);
        run_request(1'b1, 32'h0020_0134, 32'hdead_beef, 4'b0101, 1'b1);
        run_request(1'b0, 32'h0020_0134, 32'h0, 4'b0000, 1'b1);
        run_request(1'b1, 32'h0020_0134, 32'h7700_0000, 4'b1000, 1'b1);
        run_request(1'b0, 32'h0020_0134, 32'h0, 4'b0000, 1'b1);

        run_random(NUM_RANDOM);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== dcache.f ====
verilog/dcache_pkg.sv
verilog/dcache_way.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/axi_mem_model.sv
sim/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
